// File: logic/mcu_consts.svh
`ifndef MCU_CONSTS_SVH
`define MCU_CONSTS_SVH

// --------------------------------------------------
// Word and address widths
// --------------------------------------------------
`define BYTE_W      8
`define CODE_AW     8
`define DATA_AW     8

// Lower half of the direct space
`define IRAM_DEPTH  128

// --------------------------------------------------
// SFR map
// --------------------------------------------------
`define SFR_ACC     8'hE0
`define SFR_PSW     8'hD0
`define SFR_P2      8'hA0
`define PSW_CY_BIT  7

// Reset vector
`define CODE_START  8'h00

`endif

// File: logic/isa_pkg.sv
`include "mcu_consts.svh"

package isa_pkg;

    // Supported opcodes, 8051 encodings
    typedef enum logic [`BYTE_W-1:0] {
        MOV_A_IMM = 8'h74,
        MOV_A_DIR = 8'hE5,
        MOV_DIR_A = 8'hF5,
        ADD_IMM   = 8'h24,
        SUBB_IMM  = 8'h94,
        ANL_IMM   = 8'h54,
        ORL_IMM   = 8'h44,
        XRL_IMM   = 8'h64,
        INC_A     = 8'h04,
        DEC_A     = 8'h14,
        JZ        = 8'h60,
        JNZ       = 8'h70,
        JC        = 8'h40,
        HALT      = 8'hA5
    } opcode_e;

    // Accumulator ALU functions
    typedef enum logic [2:0] {
        PASS_B, ADD, SUBB, ANL, ORL, XRL, INC, DEC
    } alu_op_e;

endpackage

// File: logic/core_pkg.sv
`include "mcu_consts.svh"

package core_pkg;

    typedef logic [`BYTE_W-1:0]  byte_t;
    typedef logic [`CODE_AW-1:0] code_addr_t;
    typedef logic [`DATA_AW-1:0] data_addr_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        IDLE, FETCH, OPERAND, EXECUTE, STOPPED
    } seq_state_e;

    // One direct-space write per cycle, carry rides along
    typedef struct packed {
        logic       en;
        data_addr_t addr;
        byte_t      data;
        logic       cy_en;
        logic       cy;
    } data_wr_t;

    typedef struct packed {
        byte_t result;
        logic  carry;
    } alu_out_t;

endpackage

// File: logic/code_memory.sv
`timescale 1ns/1ps
`include "mcu_consts.svh"

module code_memory (
    input  logic                 clock,
    input  logic                 prog_we,
    input  core_pkg::code_addr_t prog_addr,
    input  core_pkg::byte_t      prog_data,
    input  core_pkg::code_addr_t code_addr,
    output core_pkg::byte_t      code_data
);
    import core_pkg::*;

    localparam int DEPTH = 2 ** `CODE_AW;

    byte_t mem [0:DEPTH-1];

    // Loader side
    always_ff @(posedge clock) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch side, same-cycle read
    assign code_data = mem[code_addr];

endmodule

// File: logic/alu_core.sv
`timescale 1ns/1ps
`include "mcu_consts.svh"

module alu_core (
    input  isa_pkg::alu_op_e   alu_op,
    input  core_pkg::byte_t    a,
    input  core_pkg::byte_t    b,
    input  logic               cy_in,
    output core_pkg::alu_out_t res
);
    import isa_pkg::*;

    // One extra bit holds carry or borrow
    logic [`BYTE_W:0] wide;

    always_comb begin
        wide       = '0;
        res.result = b;
        res.carry  = cy_in;
        case (alu_op)
            PASS_B: res.result = b;
            ADD: begin
                wide       = {1'b0, a} + {1'b0, b};
                res.result = wide[`BYTE_W-1:0];
                res.carry  = wide[`BYTE_W];
            end
            SUBB: begin
                // Wraps negative, top bit flags the borrow
                wide       = {1'b0, a} - {1'b0, b} - {{`BYTE_W{1'b0}}, cy_in};
                res.result = wide[`BYTE_W-1:0];
                res.carry  = wide[`BYTE_W];
            end
            ANL: res.result = a & b;
            ORL: res.result = a | b;
            XRL: res.result = a ^ b;
            INC: res.result = a + 1'b1;
            DEC: res.result = a - 1'b1;
            default: res.result = b;
        endcase
    end

endmodule

// File: logic/data_space.sv
`timescale 1ns/1ps
`include "mcu_consts.svh"

module data_space (
    input  logic                 clock,
    input  logic                 rst_n,
    input  core_pkg::data_wr_t   data_wr,
    input  core_pkg::data_addr_t rd_addr,
    output core_pkg::byte_t      rd_data,
    output core_pkg::byte_t      acc,
    output logic                 carry,
    output core_pkg::byte_t      port2
);
    import core_pkg::*;

    localparam int IRAM_AW = $clog2(`IRAM_DEPTH);

    byte_t iram [0:`IRAM_DEPTH-1];
    byte_t acc_q;
    byte_t p2_q;
    byte_t psw_val;
    logic  cy_q;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `IRAM_DEPTH; i++) begin
                iram[i] <= '0;
            end
            acc_q <= '0;
            p2_q  <= '0;
            cy_q  <= 1'b0;
        end else begin
            if (data_wr.en) begin
                if (data_wr.addr < `IRAM_DEPTH) begin
                    iram[data_wr.addr[IRAM_AW-1:0]] <= data_wr.data;
                end else begin
                    case (data_wr.addr)
                        `SFR_ACC: acc_q <= data_wr.data;
                        `SFR_PSW: cy_q  <= data_wr.data[`PSW_CY_BIT];
                        `SFR_P2:  p2_q  <= data_wr.data;
                        default: ;
                    endcase
                end
            end
            // Flag update from the ALU path
            if (data_wr.cy_en) begin
                cy_q <= data_wr.cy;
            end
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_comb begin
        psw_val = '0;
        psw_val[`PSW_CY_BIT] = cy_q;
    end

    always_comb begin
        if (rd_addr < `IRAM_DEPTH) begin
            rd_data = iram[rd_addr[IRAM_AW-1:0]];
        end else begin
            case (rd_addr)
                `SFR_ACC: rd_data = acc_q;
                `SFR_PSW: rd_data = psw_val;
                `SFR_P2:  rd_data = p2_q;
                default:  rd_data = '0;
            endcase
        end
    end

    assign acc   = acc_q;
    assign carry = cy_q;
    assign port2 = p2_q;

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps
`include "mcu_consts.svh"

module control_unit (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 run,
    output core_pkg::code_addr_t code_addr,
    input  core_pkg::byte_t      code_data,
    input  core_pkg::byte_t      acc,
    input  logic                 carry,
    output core_pkg::data_addr_t rd_addr,
    input  core_pkg::byte_t      rd_data,
    output isa_pkg::alu_op_e     alu_op,
    output core_pkg::byte_t      alu_a,
    output core_pkg::byte_t      alu_b,
    output logic                 alu_cy_in,
    input  core_pkg::alu_out_t   alu_res,
    output core_pkg::data_wr_t   data_wr,
    output logic                 halted
);
    import isa_pkg::*;
    import core_pkg::*;

    seq_state_e state;
    code_addr_t pc;
    byte_t      ir;
    byte_t      operand;
    opcode_e    op;
    logic       acc_write;
    logic       take_jump;

    // Two-byte instructions carry an immediate, address or offset
    function automatic logic has_operand(input byte_t opc);
        case (opcode_e'(opc))
            MOV_A_IMM, MOV_A_DIR, MOV_DIR_A,
            ADD_IMM, SUBB_IMM, ANL_IMM, ORL_IMM, XRL_IMM,
            JZ, JNZ, JC: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    assign op        = opcode_e'(ir);
    assign code_addr = pc;
    assign rd_addr   = operand;
    assign alu_a     = acc;
    assign alu_cy_in = carry;
    assign halted    = (state == STOPPED);

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    always_comb begin
        alu_op    = PASS_B;
        alu_b     = operand;
        acc_write = 1'b0;
        take_jump = 1'b0;
        case (op)
            MOV_A_IMM: acc_write = 1'b1;
            MOV_A_DIR: begin
                alu_b     = rd_data;
                acc_write = 1'b1;
            end
            ADD_IMM:  begin alu_op = ADD;  acc_write = 1'b1; end
            SUBB_IMM: begin alu_op = SUBB; acc_write = 1'b1; end
            ANL_IMM:  begin alu_op = ANL;  acc_write = 1'b1; end
            ORL_IMM:  begin alu_op = ORL;  acc_write = 1'b1; end
            XRL_IMM:  begin alu_op = XRL;  acc_write = 1'b1; end
            INC_A:    begin alu_op = INC;  acc_write = 1'b1; end
            DEC_A:    begin alu_op = DEC;  acc_write = 1'b1; end
            JZ:       take_jump = (acc == '0);
            JNZ:      take_jump = (acc != '0);
            JC:       take_jump = carry;
            default: ;
        endcase
    end

    // Writes only leave in EXECUTE
    always_comb begin
        data_wr = '0;
        if (state == EXECUTE) begin
            if (acc_write) begin
                data_wr.en    = 1'b1;
                data_wr.addr  = `SFR_ACC;
                data_wr.data  = alu_res.result;
                data_wr.cy_en = (op == ADD_IMM) || (op == SUBB_IMM);
                data_wr.cy    = alu_res.carry;
            end else if (op == MOV_DIR_A) begin
                data_wr.en   = 1'b1;
                data_wr.addr = operand;
                data_wr.data = acc;
            end
        end
    end

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= `CODE_START;
        end else begin
            case (state)
                IDLE: begin
                    pc <= `CODE_START;
                    if (run) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    pc    <= pc + 1'b1;
                    state <= has_operand(code_data) ? OPERAND : EXECUTE;
                end
                OPERAND: begin
                    pc    <= pc + 1'b1;
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if (op == HALT) begin
                        state <= STOPPED;
                    end else begin
                        state <= FETCH;
                        // PC already points past the jump
                        if (take_jump) begin
                            pc <= pc + operand;
                        end
                    end
                end
                STOPPED: begin
                    if (!run) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == FETCH) begin
            ir <= code_data;
        end
        if (state == OPERAND) begin
            operand <= code_data;
        end
    end

endmodule

// File: logic/mcu_top.sv
`timescale 1ns/1ps

module mcu_top (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 prog_we,
    input  core_pkg::code_addr_t prog_addr,
    input  core_pkg::byte_t      prog_data,
    input  logic                 run,
    output core_pkg::byte_t      port2,
    output logic                 halted
);
    import isa_pkg::*;
    import core_pkg::*;

    code_addr_t code_addr;
    byte_t      code_data;
    byte_t      acc;
    logic       carry;
    data_addr_t rd_addr;
    byte_t      rd_data;
    alu_op_e    alu_op;
    byte_t      alu_a;
    byte_t      alu_b;
    logic       alu_cy_in;
    alu_out_t   alu_res;
    data_wr_t   data_wr;

    code_memory i_code_memory (
        .clock     (clock),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .code_addr (code_addr),
        .code_data (code_data)
    );

    control_unit i_control_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .run       (run),
        .code_addr (code_addr),
        .code_data (code_data),
        .acc       (acc),
        .carry     (carry),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_cy_in (alu_cy_in),
        .alu_res   (alu_res),
        .data_wr   (data_wr),
        .halted    (halted)
    );

    alu_core i_alu_core (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cy_in  (alu_cy_in),
        .res    (alu_res)
    );

    data_space i_data_space (
        .clock   (clock),
        .rst_n   (rst_n),
        .data_wr (data_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .acc     (acc),
        .carry   (carry),
        .port2   (port2)
    );

endmodule

// File: testbench/tb_mcu_top.sv
`timescale 1ns/1ps
`include "mcu_consts.svh"

module tb_mcu_top;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int NUM_DIRECTED = 18;
    localparam int NUM_RANDOM   = 8;
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = NUM_ROWS * 60;

    typedef enum logic [1:0] {K_ALU, K_CHAIN, K_RAM, K_JUMP} row_kind_e;

    typedef struct packed {
        row_kind_e kind;
        opcode_e   op;
        byte_t     a;
        byte_t     b;
        byte_t     expected;
    } test_row_t;

    logic       clock;
    logic       rst_n;
    logic       prog_we;
    code_addr_t prog_addr;
    byte_t      prog_data;
    logic       run;
    byte_t      port2;
    logic       halted;

    test_row_t  rows [0:NUM_ROWS-1];
    byte_t      prog_q [$];
    int         cycle_count  = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    mcu_top i_mcu_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .run       (run),
        .port2     (port2),
        .halted    (halted)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Hard stop if some program never reaches HALT
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the program never halted within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic byte_t alu_rule(input opcode_e op, input byte_t a, input byte_t b,
                                       input logic cy_in, output logic cy_out);
        int wide;
        cy_out = cy_in;
        case (op)
            ADD_IMM: begin
                wide   = int'(a) + int'(b);
                cy_out = (wide > 255);
                return byte_t'(wide & 255);
            end
            SUBB_IMM: begin
                // Borrow whenever the difference goes negative
                wide   = int'(a) - int'(b) - int'(cy_in);
                cy_out = (wide < 0);
                return byte_t'((wide + 512) & 255);
            end
            ANL_IMM: return a & b;
            ORL_IMM: return a | b;
            XRL_IMM: return a ^ b;
            INC_A:   return byte_t'((int'(a) + 1) & 255);
            DEC_A:   return byte_t'((int'(a) + 255) & 255);
            default: return b;
        endcase
    endfunction

    // Expected port2 for a whole program with carry kept between rows
    function automatic byte_t model_row(input test_row_t row, inout logic cy);
        byte_t mid;
        byte_t acc_val;
        logic  c1;
        logic  taken;
        case (row.kind)
            K_ALU: return alu_rule(row.op, row.a, row.b, cy, cy);
            K_CHAIN: begin
                mid = alu_rule(ADD_IMM, row.a, row.b, cy, c1);
                return alu_rule(SUBB_IMM, mid, row.b, c1, cy);
            end
            K_RAM: return row.a;
            default: begin
                acc_val = row.a;
                if (row.op == JC) begin
                    acc_val = alu_rule(ADD_IMM, row.a, row.b, cy, cy);
                end
                case (row.op)
                    JZ:      taken = (acc_val == 8'h00);
                    JNZ:     taken = (acc_val != 8'h00);
                    default: taken = cy;
                endcase
                return taken ? acc_val : 8'h55;
            end
        endcase
    endfunction

    // --------------------------------------------------
    // Test table
    // --------------------------------------------------
    task automatic build_table();
        logic [31:0] seed;
        logic        cy;
        opcode_e     pick [0:6];
        pick = '{ADD_IMM, SUBB_IMM, ANL_IMM, ORL_IMM, XRL_IMM, INC_A, DEC_A};
        rows[0]  = '{K_ALU,   ADD_IMM,   8'h12, 8'h34, 8'h46};
        rows[1]  = '{K_ALU,   ADD_IMM,   8'hF0, 8'h20, 8'h10};
        // Carry left set by the row above
        rows[2]  = '{K_ALU,   SUBB_IMM,  8'h50, 8'h10, 8'h3F};
        rows[3]  = '{K_CHAIN, SUBB_IMM,  8'h80, 8'h90, 8'h7F};
        rows[4]  = '{K_ALU,   SUBB_IMM,  8'h05, 8'h07, 8'hFD};
        rows[5]  = '{K_ALU,   ANL_IMM,   8'hF0, 8'h3C, 8'h30};
        rows[6]  = '{K_ALU,   ORL_IMM,   8'h0F, 8'hA0, 8'hAF};
        rows[7]  = '{K_ALU,   XRL_IMM,   8'hFF, 8'h5A, 8'hA5};
        rows[8]  = '{K_ALU,   INC_A,     8'hFF, 8'h00, 8'h00};
        rows[9]  = '{K_ALU,   DEC_A,     8'h00, 8'h00, 8'hFF};
        rows[10] = '{K_RAM,   MOV_A_DIR, 8'h6B, 8'h00, 8'h6B};
        rows[11] = '{K_RAM,   MOV_A_DIR, 8'hC3, 8'h00, 8'hC3};
        rows[12] = '{K_JUMP,  JZ,        8'h00, 8'h00, 8'h00};
        rows[13] = '{K_JUMP,  JZ,        8'h11, 8'h00, 8'h55};
        rows[14] = '{K_JUMP,  JNZ,       8'h22, 8'h00, 8'h22};
        rows[15] = '{K_JUMP,  JNZ,       8'h00, 8'h00, 8'h55};
        rows[16] = '{K_JUMP,  JC,        8'hC0, 8'h50, 8'h10};
        rows[17] = '{K_JUMP,  JC,        8'h10, 8'h20, 8'h55};
        cy = 1'b0;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            void'(model_row(rows[i], cy));
        end
        seed = 32'd15182;
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            seed = lcg_next(seed);
            rows[i].kind = K_ALU;
            rows[i].op   = pick[seed[18:16] % 7];
            rows[i].a    = seed[31:24];
            seed = lcg_next(seed);
            rows[i].b    = seed[31:24];
            rows[i].expected = model_row(rows[i], cy);
        end
    endtask

    task automatic build_program(input test_row_t row);
        prog_q.delete();
        prog_q.push_back(MOV_A_IMM);
        prog_q.push_back(row.a);
        case (row.kind)
            K_ALU: begin
                prog_q.push_back(row.op);
                if (row.op != INC_A && row.op != DEC_A) begin
                    prog_q.push_back(row.b);
                end
            end
            K_CHAIN: begin
                prog_q.push_back(ADD_IMM);
                prog_q.push_back(row.b);
                prog_q.push_back(SUBB_IMM);
                prog_q.push_back(row.b);
            end
            K_RAM: begin
                prog_q.push_back(MOV_DIR_A);
                prog_q.push_back(8'h30);
                prog_q.push_back(MOV_A_IMM);
                prog_q.push_back(8'h00);
                prog_q.push_back(MOV_A_DIR);
                prog_q.push_back(8'h30);
            end
            default: begin
                if (row.op == JC) begin
                    prog_q.push_back(ADD_IMM);
                    prog_q.push_back(row.b);
                end
                // Offset 2 skips the MOV A,#0x55
                prog_q.push_back(row.op);
                prog_q.push_back(8'h02);
                prog_q.push_back(MOV_A_IMM);
                prog_q.push_back(8'h55);
            end
        endcase
        prog_q.push_back(MOV_DIR_A);
        prog_q.push_back(`SFR_P2);
        prog_q.push_back(HALT);
    endtask

    // --------------------------------------------------
    // Load, run, check and restart one row
    // --------------------------------------------------
    task automatic apply_row(input int idx);
        test_row_t row;
        logic      ok;
        row = rows[idx];
        ok  = 1'b1;
        build_program(row);
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clock);
            prog_we   <= 1'b1;
            prog_addr <= code_addr_t'(i);
            prog_data <= prog_q[i];
        end
        @(posedge clock);
        prog_we <= 1'b0;
        run     <= 1'b1;
        do begin
            @(negedge clock);
        end while (!halted);
        assert (port2 == row.expected) else begin
            $display("Fail %0t: row %0d %s %s expected port2 %02h, got %02h", $time, idx,
                     row.kind.name(), row.op.name(), row.expected, port2);
            ok = 1'b0;
        end
        repeat (5) begin
            @(negedge clock);
            assert (port2 == row.expected && halted) else begin
                $display("Fail %0t: row %0d while stopped port2=%02h halted=%b", $time, idx,
                         port2, halted);
                ok = 1'b0;
            end
        end
        @(posedge clock);
        run <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        assert (!halted) else begin
            $display("Fail %0t: row %0d halted still high after run dropped", $time, idx);
            ok = 1'b0;
        end
        if (ok) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d %s %s a=%02h b=%02h: %s", idx, row.kind.name(), row.op.name(),
                 row.a, row.b, ok ? "ok" : "wrong");
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run       = 1'b0;
        build_table();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (port2 == 8'h00 && !halted) else begin
            $display("Fail %0t: after reset port2=%02h halted=%b", $time, port2, halted);
            tests_failed++;
        end
        $display("Test reset: port2=%02h halted=%b", port2, halted);
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/code_memory.sv
logic/alu_core.sv
logic/data_space.sv
logic/control_unit.sv
logic/mcu_top.sv
testbench/tb_mcu_top.sv

// File: Bender.yml
package:
  name: mcu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/core_pkg.sv
      - logic/code_memory.sv
      - logic/alu_core.sv
      - logic/data_space.sv
      - logic/control_unit.sv
      - logic/mcu_top.sv
      - target: test
        files:
          - testbench/tb_mcu_top.sv
